// ==== source/term_pkg.sv ====
// terminal command handler package with screen geometry, character codes and shared types
package term_pkg;

   // screen geometry, one buffer cell per character
   localparam int ROWS = 24;
   localparam int COLS = 80;
   localparam int LAST_ROW = (ROWS - 1) * COLS;
   localparam int BUF_SIZE = ROWS * COLS;

   // one byte of character data
   typedef logic [7:0] char_t;

   // screen buffer address, covers BUF_SIZE cells
   typedef logic [10:0] addr_t;

   // cursor column and row
   typedef logic [6:0] col_t;
   typedef logic [4:0] row_t;

   // control characters
   localparam char_t CHAR_BS    = 8'h08;
   localparam char_t CHAR_LF    = 8'h0a;
   localparam char_t CHAR_CR    = 8'h0d;
   localparam char_t CHAR_ESC   = 8'h1b;
   localparam char_t CHAR_SPACE = 8'h20;
   localparam char_t CHAR_DEL   = 8'h7f;

   // letters that follow ESC
   localparam char_t ESC_UP         = "A";
   localparam char_t ESC_DOWN       = "B";
   localparam char_t ESC_RIGHT      = "C";
   localparam char_t ESC_LEFT       = "D";
   localparam char_t ESC_HOME       = "H";
   localparam char_t ESC_ERASE_LINE = "K";

   // decoded operations handed from decode to execute
   typedef enum logic [3:0] {
      op_none,
      op_print,
      op_backspace,
      op_return,
      op_linefeed,
      op_up,
      op_down,
      op_right,
      op_left,
      op_home,
      op_erase_line
   } op_t;

endpackage

// ==== source/command_decode.sv ====
// command decoder that turns accepted bytes and VT52 escape sequences into operations
module command_decode (
   input  logic            clk,
   input  logic            reset,
   input  term_pkg::char_t data,
   input  logic            valid,
   input  logic            ready,
   output term_pkg::op_t   op,
   output term_pkg::char_t op_char
);

   import term_pkg::*;

   typedef enum logic {
      esc_idle,
      esc_pending
   } esc_state_t;

   esc_state_t state;
   esc_state_t next_state;
   logic       accept;

   // a byte only counts on a valid and ready handshake
   assign accept = valid && ready;

   // printed character goes along with the op
   assign op_char = data;

   always_comb begin
      op = op_none;
      next_state = state;
      if (accept) begin
         case (state)
            esc_idle: begin
               if (data >= CHAR_SPACE && data < CHAR_DEL) begin
                  op = op_print;
               end
               else begin
                  case (data)
                     CHAR_BS: begin
                        op = op_backspace;
                     end
                     CHAR_CR: begin
                        op = op_return;
                     end
                     CHAR_LF: begin
                        op = op_linefeed;
                     end
                     CHAR_ESC: begin
                        next_state = esc_pending;
                     end
                     default: begin
                        // other control bytes are ignored
                        op = op_none;
                     end
                  endcase
               end
            end
            esc_pending: begin
               // most letters close the sequence
               next_state = esc_idle;
               case (data)
                  ESC_UP: begin
                     op = op_up;
                  end
                  ESC_DOWN: begin
                     op = op_down;
                  end
                  ESC_RIGHT: begin
                     op = op_right;
                  end
                  ESC_LEFT: begin
                     op = op_left;
                  end
                  ESC_HOME: begin
                     op = op_home;
                  end
                  ESC_ERASE_LINE: begin
                     op = op_erase_line;
                  end
                  CHAR_ESC: begin
                     // two escapes do not cancel on a VT52
                     next_state = esc_pending;
                  end
                  default: begin
                     // unknown sequence, dropped
                     op = op_none;
                  end
               endcase
            end
            default: begin
               next_state = esc_idle;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= esc_idle;
      end
      else begin
         state <= next_state;
      end
   end

endmodule

// ==== source/cursor_execute.sv ====
// execute stage holding cursor, row address and scroll origin, and issuing write ranges
module cursor_execute (
   input  logic            clk,
   input  logic            reset,
   input  term_pkg::op_t   op,
   input  term_pkg::char_t op_char,
   output term_pkg::col_t  new_cursor_x,
   output term_pkg::row_t  new_cursor_y,
   output logic            new_cursor_wen,
   output term_pkg::addr_t new_first_char,
   output logic            new_first_char_wen,
   output logic            write_req,
   output term_pkg::char_t write_char,
   output term_pkg::addr_t write_first,
   output term_pkg::addr_t write_last
);

   import term_pkg::*;

   addr_t row_addr;
   addr_t char_addr;

   col_t  next_x;
   row_t  next_y;
   addr_t next_row_addr;
   addr_t next_char_addr;
   addr_t next_first_char;
   logic  move;
   logic  scroll;

   // buffer address plus offset, modulo BUF_SIZE
   function automatic addr_t wrap_add(addr_t base, int unsigned offset);
      logic [11:0] sum;
      sum = {1'b0, base} + 12'(offset);
      if (sum >= 12'(BUF_SIZE)) begin
         sum = sum - 12'(BUF_SIZE);
      end
      return addr_t'(sum);
   endfunction

   // buffer address minus offset, modulo BUF_SIZE
   function automatic addr_t wrap_sub(addr_t base, int unsigned offset);
      logic [11:0] diff;
      diff = {1'b0, base} + 12'(BUF_SIZE) - 12'(offset);
      if (diff >= 12'(BUF_SIZE)) begin
         diff = diff - 12'(BUF_SIZE);
      end
      return addr_t'(diff);
   endfunction

   always_comb begin
      next_x = new_cursor_x;
      next_y = new_cursor_y;
      next_row_addr = row_addr;
      next_char_addr = char_addr;
      next_first_char = new_first_char;
      move = 1'b0;
      scroll = 1'b0;
      write_req = 1'b0;
      write_char = CHAR_SPACE;
      write_first = char_addr;
      write_last = char_addr;
      case (op)
         op_print: begin
            write_req = 1'b1;
            write_char = op_char;
            // no wrap, the last column keeps getting overwritten
            if (new_cursor_x != col_t'(COLS - 1)) begin
               next_x = new_cursor_x + 1'b1;
               next_char_addr = wrap_add(char_addr, 1);
               move = 1'b1;
            end
         end
         op_backspace, op_left: begin
            if (new_cursor_x != '0) begin
               next_x = new_cursor_x - 1'b1;
               next_char_addr = wrap_sub(char_addr, 1);
               move = 1'b1;
            end
         end
         op_right: begin
            if (new_cursor_x != col_t'(COLS - 1)) begin
               next_x = new_cursor_x + 1'b1;
               next_char_addr = wrap_add(char_addr, 1);
               move = 1'b1;
            end
         end
         op_return: begin
            if (new_cursor_x != '0) begin
               next_x = '0;
               next_char_addr = row_addr;
               move = 1'b1;
            end
         end
         op_up: begin
            if (new_cursor_y != '0) begin
               next_y = new_cursor_y - 1'b1;
               next_row_addr = wrap_sub(row_addr, COLS);
               next_char_addr = wrap_sub(char_addr, COLS);
               move = 1'b1;
            end
         end
         op_down, op_linefeed: begin
            if (new_cursor_y != row_t'(ROWS - 1)) begin
               next_y = new_cursor_y + 1'b1;
               next_row_addr = wrap_add(row_addr, COLS);
               next_char_addr = wrap_add(char_addr, COLS);
               move = 1'b1;
            end
            else if (op == op_linefeed) begin
               // bottom row, scroll and blank the row that comes into view
               scroll = 1'b1;
               next_first_char = (new_first_char == addr_t'(LAST_ROW)) ?
                                 '0 : new_first_char + addr_t'(COLS);
               next_row_addr = wrap_add(row_addr, COLS);
               next_char_addr = wrap_add(char_addr, COLS);
               write_req = 1'b1;
               write_first = new_first_char;
               write_last = wrap_add(new_first_char, COLS - 1);
            end
         end
         op_home: begin
            next_x = '0;
            next_y = '0;
            next_row_addr = new_first_char;
            next_char_addr = new_first_char;
            move = (new_cursor_x != '0) || (new_cursor_y != '0);
         end
         op_erase_line: begin
            write_req = 1'b1;
            write_first = char_addr;
            write_last = wrap_add(row_addr, COLS - 1);
         end
         default: begin
            move = 1'b0;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         new_cursor_x <= '0;
         new_cursor_y <= '0;
         new_cursor_wen <= 1'b0;
         new_first_char <= '0;
         new_first_char_wen <= 1'b0;
         row_addr <= '0;
         char_addr <= '0;
      end
      else begin
         new_cursor_x <= next_x;
         new_cursor_y <= next_y;
         new_first_char <= next_first_char;
         row_addr <= next_row_addr;
         char_addr <= next_char_addr;
         // enables last one cycle
         new_cursor_wen <= move;
         new_first_char_wen <= scroll;
      end
   end

endmodule

// ==== source/write_sequencer.sv ====
// write sequencer that walks one buffer address range per request and drives ready
module write_sequencer (
   input  logic            clk,
   input  logic            reset,
   input  logic            write_req,
   input  term_pkg::char_t write_char,
   input  term_pkg::addr_t write_first,
   input  term_pkg::addr_t write_last,
   output term_pkg::char_t new_char,
   output term_pkg::addr_t new_char_address,
   output logic            new_char_wen,
   output logic            ready
);

   import term_pkg::*;

   // final address of the range in flight
   addr_t last_addr;

   addr_t next_addr;
   logic  on_last;

   // current write is the final one of its range
   assign on_last = (new_char_address == last_addr);

   // step through the buffer, wrapping at its end
   assign next_addr = (new_char_address == addr_t'(BUF_SIZE - 1)) ?
                      '0 : new_char_address + 1'b1;

   // only back-pressure point, a new byte may come in on the last write
   assign ready = !new_char_wen || on_last;

   // enable stays up until the last address has been written
   always_ff @(posedge clk) begin
      if (reset) begin
         new_char_wen <= 1'b0;
      end
      else if (write_req) begin
         new_char_wen <= 1'b1;
      end
      else if (on_last) begin
         new_char_wen <= 1'b0;
      end
   end

   // range latch and address walk
   always_ff @(posedge clk) begin
      if (write_req) begin
         new_char <= write_char;
         new_char_address <= write_first;
         last_addr <= write_last;
      end
      else if (new_char_wen && !on_last) begin
         new_char_address <= next_addr;
      end
   end

endmodule

// ==== source/command_handler.sv ====
// terminal command handler top with decode, cursor execute and write sequencer stages
module command_handler (
   input  logic            clk,
   input  logic            reset,
   input  term_pkg::char_t data,
   input  logic            valid,
   output logic            ready,
   output term_pkg::char_t new_char,
   output term_pkg::addr_t new_char_address,
   output logic            new_char_wen,
   output term_pkg::col_t  new_cursor_x,
   output term_pkg::row_t  new_cursor_y,
   output logic            new_cursor_wen,
   output term_pkg::addr_t new_first_char,
   output logic            new_first_char_wen
);

   import term_pkg::*;

   // decode to execute
   op_t   op;
   char_t op_char;

   // execute to sequencer
   logic  write_req;
   char_t write_char;
   addr_t write_first;
   addr_t write_last;

   command_decode u_decode (
      .clk     (clk),
      .reset   (reset),
      .data    (data),
      .valid   (valid),
      .ready   (ready),
      .op      (op),
      .op_char (op_char)
   );

   cursor_execute u_execute (
      .clk                (clk),
      .reset              (reset),
      .op                 (op),
      .op_char            (op_char),
      .new_cursor_x       (new_cursor_x),
      .new_cursor_y       (new_cursor_y),
      .new_cursor_wen     (new_cursor_wen),
      .new_first_char     (new_first_char),
      .new_first_char_wen (new_first_char_wen),
      .write_req          (write_req),
      .write_char         (write_char),
      .write_first        (write_first),
      .write_last         (write_last)
   );

   write_sequencer u_sequencer (
      .clk              (clk),
      .reset            (reset),
      .write_req        (write_req),
      .write_char       (write_char),
      .write_first      (write_first),
      .write_last       (write_last),
      .new_char         (new_char),
      .new_char_address (new_char_address),
      .new_char_wen     (new_char_wen),
      .ready            (ready)
   );

endmodule

// ==== test/tb_tasks.svh ====
// testbench tasks for byte transfer, output checks and the directed tests

   task automatic check_value(string what, logic [31:0] expected, logic [31:0] actual);
      if (expected !== actual) begin
         $display("ERROR: %s: %s expected %0h actual %0h", test_name, what, expected, actual);
         stop_with_failure();
      end
   endtask

   task automatic check_write();
      bit last;
      if (pend_addr_q.size() == 0) begin
         $display("%s: DUT wrote at address %0d when no write was due",
                  test_name, new_char_address);
         stop_with_failure();
      end
      else begin
         check_value("write address", 32'(pend_addr_q.pop_front()), 32'(new_char_address));
         // ready only during the final write of a range
         last = pend_last_q.pop_front();
         check_value("ready during write", 32'(last), 32'(ready));
         range_open = !last;
         screen[new_char_address] = new_char;
      end
   endtask

   task automatic check_cursor_pulse();
      if (pend_x_q.size() == 0) begin
         $display("%s: DUT reported a cursor move that was not due", test_name);
         stop_with_failure();
      end
      else begin
         check_value("cursor column", 32'(pend_x_q.pop_front()), 32'(new_cursor_x));
         check_value("cursor row", 32'(pend_y_q.pop_front()), 32'(new_cursor_y));
      end
   endtask

   task automatic check_scroll_pulse();
      if (pend_origin_q.size() == 0) begin
         $display("%s: DUT scrolled when no scroll was due", test_name);
         stop_with_failure();
      end
      else begin
         check_value("scroll origin", 32'(pend_origin_q.pop_front()), 32'(new_first_char));
      end
   endtask

   task automatic check_position();
      check_value("cursor column", 32'(exp_x), 32'(new_cursor_x));
      check_value("cursor row", 32'(exp_y), 32'(new_cursor_y));
      check_value("scroll origin", 32'(exp_origin), 32'(new_first_char));
   endtask

   task automatic compare_screen();
      for (int a = 0; a < BUF_SIZE; a++) begin
         if (screen[a] !== exp_screen[a]) begin
            check_value($sformatf("screen cell %0d", a), 32'(exp_screen[a]), 32'(screen[a]));
         end
      end
   endtask

   function automatic char_t random_printable();
      return 8'(CHAR_SPACE + $urandom_range(94));
   endfunction

   // starts and ends 1 ns after a rising edge, byte is held until ready
   task automatic send_byte(char_t b);
      bit taken;
      model_byte(b);
      data = b;
      valid = 1'b1;
      taken = 1'b0;
      while (!taken) begin
         @(negedge clk);
         taken = ready;
         @(posedge clk);
         #1;
      end
      valid = 1'b0;
   endtask

   task automatic send_escape(char_t letter);
      send_byte(CHAR_ESC);
      send_byte(letter);
   endtask

   task automatic idle_gap();
      repeat ($urandom_range(2)) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic wait_idle();
      while (pend_addr_q.size() != 0 || pend_x_q.size() != 0 || pend_origin_q.size() != 0) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic check_reset_state();
      test_name = "reset";
      check_value("ready", 1, 32'(ready));
      check_value("char write enable", 0, 32'(new_char_wen));
      check_value("cursor write enable", 0, 32'(new_cursor_wen));
      check_value("scroll write enable", 0, 32'(new_first_char_wen));
      check_position();
      // quiet window, the monitor catches any stray enable
      repeat (4) @(posedge clk);
      #1;
      send_byte("a");
      wait_idle();
      check_value("first character at address 0", 32'("a"), 32'(screen[0]));
      check_value("cursor column", 1, 32'(new_cursor_x));
      check_value("cursor row", 0, 32'(new_cursor_y));
   endtask

   task automatic print_random_text();
      test_name = "printing";
      // runs past the right edge so the last cell is overwritten
      repeat (COLS + 10) begin
         idle_gap();
         send_byte(random_printable());
      end
      wait_idle();
      check_value("saturated column", COLS - 1, 32'(new_cursor_x));
      send_byte(8'h07);
      wait_idle();
      check_position();
      compare_screen();
   endtask

   task automatic move_cursor_around();
      test_name = "cursor motion";
      send_byte(CHAR_CR);
      send_byte(CHAR_BS);
      send_escape(ESC_UP);
      repeat (3) send_escape(ESC_DOWN);
      send_escape(ESC_UP);
      repeat (2) send_escape(ESC_RIGHT);
      send_escape(ESC_LEFT);
      send_byte(CHAR_BS);
      send_byte("m");
      wait_idle();
      check_position();
      send_escape(ESC_HOME);
      send_escape(ESC_LEFT);
      send_byte("h");
      wait_idle();
      check_position();
      compare_screen();
   endtask

   task automatic erase_rest_of_line();
      test_name = "erase line";
      send_byte(CHAR_CR);
      repeat (5) send_escape(ESC_RIGHT);
      wait_idle();
      // the next byte waits with valid high while the spaces go out
      send_escape(ESC_ERASE_LINE);
      send_byte("x");
      wait_idle();
      check_position();
      compare_screen();
   endtask

   task automatic scroll_full_screen();
      test_name = "scrolling";
      while (exp_y < ROWS - 1) send_byte(CHAR_LF);
      for (int i = 1; i <= ROWS; i++) begin
         send_byte(CHAR_LF);
         if (i % 8 == 0) send_byte(random_printable());
      end
      wait_idle();
      check_value("origin after full wrap", 0, 32'(new_first_char));
      send_escape(ESC_DOWN);
      repeat (5) send_byte(random_printable());
      wait_idle();
      check_position();
      compare_screen();
   endtask

   task automatic escape_corner_cases();
      test_name = "escape handling";
      send_byte(CHAR_CR);
      send_byte(CHAR_ESC);
      send_escape(ESC_RIGHT);
      wait_idle();
      check_value("column after ESC ESC C", 1, 32'(new_cursor_x));
      send_escape("Q");
      send_byte("p");
      wait_idle();
      check_position();
      compare_screen();
   endtask

// ==== test/command_handler_tb.sv ====
// testbench for the terminal command handler with a screen and cursor reference model
module command_handler_tb;

   timeunit 1ns;
   timeprecision 100ps;

   import term_pkg::*;

   localparam int clk_period = 4;
   localparam int reset_cycles = 4;
   // upper bound on the bytes sent by all tests together
   localparam int byte_budget = 200;
   localparam int timeout_ns = (reset_cycles + byte_budget * (COLS + 4)) * clk_period;

   logic  clk;
   logic  reset;
   char_t data;
   logic  valid;
   logic  ready;
   char_t new_char;
   addr_t new_char_address;
   logic  new_char_wen;
   col_t  new_cursor_x;
   row_t  new_cursor_y;
   logic  new_cursor_wen;
   addr_t new_first_char;
   logic  new_first_char_wen;

   // reference model of cursor, row address, origin and escape mode
   int exp_x;
   int exp_y;
   int exp_row;
   int exp_origin;
   bit exp_esc;

   // screen as written by the DUT and as the model expects it
   char_t screen [BUF_SIZE];
   char_t exp_screen [BUF_SIZE];

   // DUT outputs predicted but not yet seen
   int    pend_addr_q[$];
   bit    pend_last_q[$];
   int    pend_x_q[$];
   int    pend_y_q[$];
   int    pend_origin_q[$];

   string test_name;
   bit    monitor_on;
   // a range is being written and its next address is due next cycle
   bit    range_open;

   command_handler i_dut (
      .clk                (clk),
      .reset              (reset),
      .data               (data),
      .valid              (valid),
      .ready              (ready),
      .new_char           (new_char),
      .new_char_address   (new_char_address),
      .new_char_wen       (new_char_wen),
      .new_cursor_x       (new_cursor_x),
      .new_cursor_y       (new_cursor_y),
      .new_cursor_wen     (new_cursor_wen),
      .new_first_char     (new_first_char),
      .new_first_char_wen (new_first_char_wen)
   );

   `include "tb_tasks.svh"

   task automatic stop_with_failure();
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped at the first failure");
   endtask

   function automatic int wrap_addr(int a);
      return ((a % BUF_SIZE) + BUF_SIZE) % BUF_SIZE;
   endfunction

   function automatic void init_model();
      exp_x = 0;
      exp_y = 0;
      exp_row = 0;
      exp_origin = 0;
      exp_esc = 1'b0;
      range_open = 1'b0;
      for (int a = 0; a < BUF_SIZE; a++) begin
         // fill depends on every address bit
         screen[a] = 8'(a) ^ 8'(a >> 8);
         exp_screen[a] = screen[a];
      end
   endfunction

   function automatic void expect_write(int addr, char_t c, bit last);
      pend_addr_q.push_back(addr);
      pend_last_q.push_back(last);
      exp_screen[addr] = c;
   endfunction

   function automatic void move_cursor(int x, int y);
      exp_x = x;
      exp_y = y;
      pend_x_q.push_back(x);
      pend_y_q.push_back(y);
   endfunction

   function automatic void model_down(bit linefeed);
      if (exp_y < ROWS - 1) begin
         exp_row = wrap_addr(exp_row + COLS);
         move_cursor(exp_x, exp_y + 1);
      end
      else if (linefeed) begin
         // old top row comes back as the new bottom row, blanked
         for (int i = 0; i < COLS; i++) begin
            expect_write(wrap_addr(exp_origin + i), CHAR_SPACE, i == COLS - 1);
         end
         exp_origin = wrap_addr(exp_origin + COLS);
         pend_origin_q.push_back(exp_origin);
         exp_row = wrap_addr(exp_row + COLS);
      end
   endfunction

   function automatic void model_byte(char_t b);
      if (!exp_esc) begin
         if (b >= CHAR_SPACE && b < CHAR_DEL) begin
            expect_write(wrap_addr(exp_row + exp_x), b, 1'b1);
            if (exp_x < COLS - 1) move_cursor(exp_x + 1, exp_y);
         end
         else if (b == CHAR_BS && exp_x > 0) move_cursor(exp_x - 1, exp_y);
         else if (b == CHAR_CR && exp_x > 0) move_cursor(0, exp_y);
         else if (b == CHAR_LF) model_down(1'b1);
         else if (b == CHAR_ESC) exp_esc = 1'b1;
      end
      else begin
         // only a second ESC keeps the sequence open
         exp_esc = (b == CHAR_ESC);
         case (b)
            ESC_UP: begin
               if (exp_y > 0) begin
                  exp_row = wrap_addr(exp_row - COLS);
                  move_cursor(exp_x, exp_y - 1);
               end
            end
            ESC_DOWN: model_down(1'b0);
            ESC_RIGHT: if (exp_x < COLS - 1) move_cursor(exp_x + 1, exp_y);
            ESC_LEFT: if (exp_x > 0) move_cursor(exp_x - 1, exp_y);
            ESC_HOME: begin
               exp_row = exp_origin;
               if (exp_x != 0 || exp_y != 0) move_cursor(0, 0);
            end
            ESC_ERASE_LINE: begin
               for (int i = exp_x; i < COLS; i++) begin
                  expect_write(wrap_addr(exp_row + i), CHAR_SPACE, i == COLS - 1);
               end
            end
            default: ;
         endcase
      end
   endfunction

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   // outputs are stable at the falling edge
   always @(negedge clk) begin
      if (monitor_on) begin
         if (new_char_wen) begin
            check_write();
         end
         else if (range_open) begin
            $display("%s: write range stopped before its last address", test_name);
            stop_with_failure();
         end
         if (new_cursor_wen) check_cursor_pulse();
         if (new_first_char_wen) check_scroll_pulse();
      end
   end

   initial begin
      #(timeout_ns);
      $display("watchdog: tests still running after %0d ns, run timed out", timeout_ns);
      stop_with_failure();
   end

   initial begin
      void'($urandom(32'h747893cb));
      data = '0;
      valid = 1'b0;
      reset = 1'b1;
      monitor_on = 1'b0;
      test_name = "reset";
      init_model();
      repeat (reset_cycles) @(posedge clk);
      #1;
      reset = 1'b0;
      monitor_on = 1'b1;
      check_reset_state();
      print_random_text();
      move_cursor_around();
      erase_rest_of_line();
      scroll_full_screen();
      escape_corner_cases();
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

// ==== filelist.f ====
+incdir+test
source/term_pkg.sv
source/command_decode.sv
source/cursor_execute.sv
source/write_sequencer.sv
source/command_handler.sv
test/command_handler_tb.sv

// ==== Makefile ====
# Verilator build and run for the terminal command handler testbench

VERILATOR ?= verilator
TOP       ?= command_handler_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the pass message shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
